// File: cia_pkg.sv
//--------------------
// cia subsystem definitions
// address map, register numbers, irq levels and bus types
//--------------------

package cia_pkg;

	//--------------------
	// address map
	//--------------------
	localparam int num_cias = 2;	// timer channels, channel i on byte lane i

	localparam logic [7:0] cia_region = 8'hbf;	// addr[23:16] of cia space
	localparam int cia_sel_bit_base = 12;	// channel i selected by addr[12+i] low

	// register select, taken from addr[11:8]
	localparam logic [3:0] reg_talo = 4'd4;	// timer a low byte
	localparam logic [3:0] reg_tahi = 4'd5;	// timer a high byte
	localparam logic [3:0] reg_icr = 4'd13;	// interrupt control
	localparam logic [3:0] reg_cra = 4'd14;	// control register a

	// cpu priority level per channel, cia a on int2 and cia b on int6
	localparam logic [num_cias-1:0][2:0] irq_level = {3'd6, 3'd2};

	//--------------------
	// bus types
	//--------------------
	typedef struct packed {
		logic [23:1] addr;	// word address
		logic        we;	// write when set
		logic [15:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [15:0] rdata;	// lane i holds channel i
	} cpu_rsp_t;

	// one access to the timer channels, valid for a single cycle
	typedef struct packed {
		logic                valid;
		logic [num_cias-1:0] sel;	// per-channel select, may be all zero
		logic                we;
		logic [3:0]          rs;	// register number
		logic [15:0]         wdata;	// full word, each channel takes its lane
	} cia_access_t;

	// timer write byte, seen as cra or as icr set/clear word
	typedef union packed {
		struct packed {
			logic [2:0] unused_hi;
			logic       load;	// force load, strobe only
			logic       oneshot;
			logic [1:0] unused_lo;
			logic       start;
		} cra;
		struct packed {
			logic       set_clr;	// 1 sets the given mask bits, 0 clears them
			logic [5:0] unused;
			logic       ta;	// timer a mask bit
		} icr;
	} cia_wbyte_u;

endpackage

// File: cia_bus_decoder.sv
//--------------------
// cia bus decoder
// accepts one cpu request at a time, decodes the cia space
// and issues a registered single-cycle access to the timers
//--------------------

`timescale 1ns/1ps

module cia_bus_decoder
	import cia_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        req_valid_i,
	input  cpu_req_t    req_i,
	output logic        req_ready_o,
	input  logic        rsp_done_i,	// response taken by the cpu side
	output cia_access_t access_o
);

	logic                busy;	// access in flight
	logic                accept;
	logic                in_region;
	logic [num_cias-1:0] sel_dec;

	// access register, control part
	logic                acc_valid;
	logic [num_cias-1:0] acc_sel;

	// access register, payload part
	logic                acc_we;
	logic [3:0]          acc_rs;
	logic [15:0]         acc_wdata;

	assign req_ready_o = ~busy;
	assign accept = req_valid_i & ~busy;

	//--------------------
	// address decode
	//--------------------
	assign in_region = (req_i.addr[23:16] == cia_region);

	always_comb begin
		for (int i = 0; i < num_cias; i++) begin
			sel_dec[i] = in_region & ~req_i.addr[cia_sel_bit_base + i];	// active low select
		end
	end

	//--------------------
	// busy and access registers
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			acc_valid <= 1'b0;
			acc_sel <= '0;
		end else begin
			if (accept)
				busy <= 1'b1;
			else if (rsp_done_i)
				busy <= 1'b0;	// ready again next cycle
			acc_valid <= accept;	// one cycle pulse
			acc_sel <= accept ? sel_dec : '0;	// unmapped still issues, answers zero
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			acc_we <= req_i.we;
			acc_rs <= req_i.addr[11:8];
			acc_wdata <= req_i.wdata;
		end
	end

	always_comb begin
		access_o.valid = acc_valid;
		access_o.sel = acc_sel;
		access_o.we = acc_we;
		access_o.rs = acc_rs;
		access_o.wdata = acc_wdata;
	end

	// next access only after the combiner has handed off the response
	assert property (@(posedge clk) disable iff (reset)
		access_o.valid |=> !access_o.valid until rsp_done_i)
		else $error("cia access issued while previous one in flight");

endmodule

// File: cia_timer.sv
//--------------------
// cia timer a
// latch, down counter, control register and icr
// one instance per byte lane
//--------------------

`timescale 1ns/1ps

module cia_timer
	import cia_pkg::*;
#(
	parameter int lane = 0	// byte lane and select bit, 0 .. num_cias-1
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        tick_i,	// count enable
	input  cia_access_t access_i,
	output logic [7:0]  rdata_o,
	output logic        irq_o
);

	logic        hit;	// this channel addressed
	logic        wr;
	logic        rd;
	logic [7:0]  wdata_byte;
	cia_wbyte_u  wbyte;
	logic        underflow;
	logic        icr_rd;

	logic [15:0] latch;
	logic [15:0] counter;
	logic        start;
	logic        oneshot;
	logic        flag;	// icr timer a flag
	logic        mask;	// icr timer a enable

	if (lane < 0 || lane >= num_cias) begin : g_lane_check
		$error("cia_timer lane out of range");
	end

	assign hit = access_i.valid & access_i.sel[lane];
	assign wr = hit & access_i.we;
	assign rd = hit & ~access_i.we;
	assign wdata_byte = access_i.wdata[lane*8 +: 8];	// own lane of the word
	assign wbyte = wdata_byte;

	assign underflow = tick_i & start & (counter == 16'd0);
	assign icr_rd = rd & (access_i.rs == reg_icr);
	assign irq_o = flag & mask;

	//--------------------
	// counter and registers
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			latch <= '0;
			counter <= '0;
			start <= 1'b0;
			oneshot <= 1'b0;
			flag <= 1'b0;
			mask <= 1'b0;
		end else begin
			// count down, reload on zero
			if (tick_i && start) begin
				if (counter == 16'd0) begin
					counter <= latch;
					if (oneshot)
						start <= 1'b0;	// one-shot stops itself
				end else begin
					counter <= counter - 16'd1;
				end
			end

			// underflow wins over read clear
			if (underflow)
				flag <= 1'b1;
			else if (icr_rd)
				flag <= 1'b0;

			if (wr) begin
				case (access_i.rs)
					reg_talo: latch[7:0] <= wdata_byte;
					reg_tahi: latch[15:8] <= wdata_byte;
					reg_cra: begin
						start <= wbyte.cra.start;	// cpu write overrides one-shot stop
						oneshot <= wbyte.cra.oneshot;
						if (wbyte.cra.load)
							counter <= latch;
					end
					reg_icr: begin
						if (wbyte.icr.ta)
							mask <= wbyte.icr.set_clr;
					end
					default: ;
				endcase
			end
		end
	end

	//--------------------
	// read byte, held until next access
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rdata_o <= '0;
		end else if (access_i.valid) begin
			if (rd) begin
				case (access_i.rs)
					reg_talo: rdata_o <= counter[7:0];
					reg_tahi: rdata_o <= counter[15:8];
					reg_cra: rdata_o <= {4'b0000, oneshot, 2'b00, start};	// load reads 0
					reg_icr: rdata_o <= {irq_o, 6'b000000, flag};
					default: rdata_o <= '0;
				endcase
			end else begin
				rdata_o <= '0;	// writes and other lanes answer zero
			end
		end
	end

	// flag only drops through an icr read
	assert property (@(posedge clk) disable iff (reset)
		flag && !icr_rd |=> flag)
		else $error("cia timer flag cleared without icr read");

endmodule

// File: cia_data_combiner.sv
//--------------------
// cia data combiner
// merges lane bytes into the response and encodes the cpu irq level
//--------------------

`timescale 1ns/1ps

module cia_data_combiner
	import cia_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  cia_access_t              access_i,	// only valid is looked at
	input  logic [num_cias-1:0][7:0] rdata_i,
	input  logic [num_cias-1:0]      irq_i,
	output logic                     rsp_valid_o,
	output cpu_rsp_t                 rsp_o,
	input  logic                     rsp_ready_i,
	output logic                     rsp_done_o,
	output logic [2:0]               ipl_o
);

	logic [2:0] ipl_next;

	assign rsp_done_o = rsp_valid_o & rsp_ready_i;

	// timer bytes land together with valid and stay until the next access
	always_comb begin
		rsp_o.rdata = '0;
		if (rsp_valid_o) begin
			for (int i = 0; i < num_cias; i++) begin
				rsp_o.rdata[i*8 +: 8] = rdata_i[i];	// channel i on lane i
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			rsp_valid_o <= 1'b0;
		else if (access_i.valid)
			rsp_valid_o <= 1'b1;	// timers answer on this edge
		else if (rsp_done_o)
			rsp_valid_o <= 1'b0;
	end

	//--------------------
	// interrupt level
	//--------------------
	always_comb begin
		ipl_next = 3'd0;
		for (int i = 0; i < num_cias; i++) begin
			if (irq_i[i] && irq_level[i] > ipl_next)
				ipl_next = irq_level[i];	// highest pending wins
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			ipl_o <= 3'd0;
		else
			ipl_o <= ipl_next;
	end

	// response held under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
		else $error("cia response changed before it was taken");

endmodule

// File: cia_subsystem.sv
//--------------------
// cia subsystem top
// decoder, one timer per byte lane, response combiner
//--------------------

`timescale 1ns/1ps

module cia_subsystem
	import cia_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     tick_i,
	input  logic     req_valid_i,
	input  cpu_req_t req_i,
	output logic     req_ready_o,
	output logic     rsp_valid_o,
	output cpu_rsp_t rsp_o,
	input  logic     rsp_ready_i,
	output logic [2:0] ipl_o
);

	cia_access_t              access;
	logic                     rsp_done;
	logic [num_cias-1:0][7:0] rdata;
	logic [num_cias-1:0]      irq;

	cia_bus_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.req_ready_o (req_ready_o),
		.rsp_done_i  (rsp_done),
		.access_o    (access)
	);

	// cia a on lane 0, cia b on lane 1
	for (genvar i = 0; i < num_cias; i++) begin : g_cia
		cia_timer #(.lane(i)) u_timer (
			.clk      (clk),
			.reset    (reset),
			.tick_i   (tick_i),
			.access_i (access),
			.rdata_o  (rdata[i]),
			.irq_o    (irq[i])
		);
	end

	cia_data_combiner u_combiner (
		.clk         (clk),
		.reset       (reset),
		.access_i    (access),
		.rdata_i     (rdata),
		.irq_i       (irq),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_done_o  (rsp_done),
		.ipl_o       (ipl_o)
	);

endmodule

// File: tb_clock_gen.sv
//--------------------
// testbench clock and reset
// 20 ns clock, reset held for 3 cycles
//--------------------

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);	// three reset edges
		@(negedge clk);
		reset = 1'b0;	// released on a falling edge
	end

endmodule

// File: cia_subsystem_tb.sv
//--------------------
// cia subsystem testbench
// runs the operation list from the data file
// with random response back-pressure
//--------------------

`timescale 1ns/1ps

module cia_subsystem_tb
	import cia_pkg::*;
();

	logic        clk;
	logic        reset;
	logic        tick;
	logic        req_valid;
	cpu_req_t    req;
	logic        req_ready;
	logic        rsp_valid;
	cpu_rsp_t    rsp;
	logic        rsp_ready;
	logic [2:0]  ipl;

	logic [31:0] tdata [0:319];	// 5 words per operation
	logic [31:0] lcg_state;
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;	// zero until the data file is read
	int          num_ops;

	tb_clock_gen u_clock (
		.clk   (clk),
		.reset (reset)
	);

	cia_subsystem dut0 (
		.clk         (clk),
		.reset       (reset),
		.tick_i      (tick),
		.req_valid_i (req_valid),
		.req_i       (req),
		.req_ready_o (req_ready),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp),
		.rsp_ready_i (rsp_ready),
		.ipl_o       (ipl)
	);

	//--------------------
	// helpers
	//--------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_run(input string why);
		$display("Some tests failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp.rdata,
				got.rdata);
			stop_run("response data mismatch");
		end
	endtask

	task automatic check_level(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
			stop_run("interrupt level mismatch");
		end
	endtask

	// exactly n count edges, tick low again afterwards
	task automatic run_ticks(input int n);
		repeat (n) begin
			@(negedge clk);
			tick = 1'b1;
		end
		@(negedge clk);
		tick = 1'b0;
	endtask

	// one request, then wait for its response under random back-pressure
	task automatic run_access(input logic we, input logic [23:0] addr, input logic [15:0] wdata,
			input logic [15:0] exp_data);
		cpu_rsp_t exp;
		cpu_rsp_t held;
		int       waited;
		logic     seen;
		logic     done;
		exp.rdata = exp_data;
		@(negedge clk);
		req_valid = 1'b1;
		req.addr = addr[23:1];	// byte address in the file
		req.we = we;
		req.wdata = wdata;
		while (!req_ready)
			@(negedge clk);
		@(negedge clk);	// accepted on the edge in between
		req_valid = 1'b0;
		waited = 1;
		seen = 1'b0;
		done = 1'b0;
		while (!done) begin
			if (req_ready)
				stop_run("request ready came back before the response was taken");
			if (rsp_valid) begin
				if (!seen && waited != 2)
					stop_run("response did not arrive two cycles after acceptance");
				if (seen)
					check_rsp("rsp_o (held)", rsp, held);
				seen = 1'b1;
				held = rsp;
			end
			lcg_state = lcg_next(lcg_state);
			rsp_ready = (lcg_state[31:30] != 2'b00);	// drop ready one cycle in four
			done = rsp_valid & rsp_ready;
			if (done)
				check_rsp("rsp_o", rsp, exp);
			@(negedge clk);
			waited++;
		end
		rsp_ready = 1'b0;
		if (!req_ready)
			stop_run("request ready stayed low after the response was taken");
	endtask

	// run length guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
			stop_run("timeout, the run took longer than the operation list allows");
	end

	//--------------------
	// main sequence
	//--------------------
	initial begin
		int unsigned budget;
		logic [31:0] op;
		tick = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		lcg_state = 32'h2af4_cd5e;
		$readmemh("cia_subsystem_testdata.txt", tdata);

		// count operations, sum gaps and ticks
		num_ops = 0;
		budget = 0;
		while (num_ops < $size(tdata) / 5 && tdata[5*num_ops] !== 32'hf) begin
			if ($isunknown(tdata[5*num_ops]))
				stop_run("data file ended without an end marker");
			budget += tdata[5*num_ops+4];
			if (tdata[5*num_ops] == 32'h3)
				budget += tdata[5*num_ops+2];
			num_ops++;
		end
		cycle_limit = 20 + budget + 40 * num_ops;	// margin per op for back-pressure

		@(negedge clk);
		while (reset)
			@(negedge clk);
		if (!req_ready || rsp_valid)
			stop_run("handshake outputs not at their reset values");
		check_level("ipl_o", ipl, 3'd0);

		for (int i = 0; i < num_ops; i++) begin
			op = tdata[5*i];
			case (op)
				32'h1: run_access(1'b1, tdata[5*i+1][23:0], tdata[5*i+2][15:0], tdata[5*i+3][15:0]);
				32'h2: run_access(1'b0, tdata[5*i+1][23:0], 16'h0000, tdata[5*i+3][15:0]);
				32'h3: run_ticks(int'(tdata[5*i+2]));
				32'h4: check_level("ipl_o", ipl, tdata[5*i+3][2:0]);
				default: stop_run("unknown operation in the data file");
			endcase
			repeat (tdata[5*i+4]) @(negedge clk);	// idle gap
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// File: cia_subsystem_testdata.txt
// columns: op addr data expect gap, all hex, addr is the byte address
// op 1 write, 2 read, 3 ticks (count in data), 4 irq level check, f end of list
// both channels, latch and force load
1 bfc400 5634 0000 0
1 bfc500 7812 0000 0
1 bfce00 1010 0000 0
2 bfc400 0000 5634 0
2 bfc500 0000 7812 1
2 bfe400 0000 0034 0
2 bfd500 0000 7800 0
2 bfce00 0000 0000 0
// channel 0 continuous, latch 5
1 bfe400 0005 0000 0
1 bfe500 0000 0000 0
1 bfee00 0011 0000 0
3 000000 0003 0000 1
2 bfe400 0000 0002 0
3 000000 0003 0000 1
2 bfe400 0000 0005 0
3 000000 0001 0000 1
2 bfe400 0000 0004 0
1 bfee00 0000 0000 0
2 bfed00 0000 0001 0
2 bfed00 0000 0000 0
4 000000 0000 0000 0
// channel 1 one-shot, latch 2
1 bfd400 0200 0000 0
1 bfd500 0000 0000 0
1 bfde00 1900 0000 0
2 bfde00 0000 0900 0
3 000000 0003 0000 1
2 bfde00 0000 0800 0
2 bfd400 0000 0200 0
3 000000 0002 0000 1
2 bfd400 0000 0200 0
2 bfdd00 0000 0100 0
2 bfdd00 0000 0000 0
// masks and interrupt level
1 bfcd00 8181 0000 0
4 000000 0000 0000 0
1 bfee00 0019 0000 0
3 000000 0006 0000 1
4 000000 0000 0002 0
1 bfde00 1900 0000 0
3 000000 0003 0000 1
4 000000 0000 0006 0
1 bfdd00 0100 0000 1
4 000000 0000 0002 0
2 bfed00 0000 0081 1
4 000000 0000 0000 0
2 bfdd00 0000 0100 0
2 bfcd00 0000 0000 0
// unmapped reads and back-to-back traffic
2 a0c400 0000 0000 0
2 bff400 0000 0000 0
2 bfc000 0000 0000 0
2 bfc400 0000 0205 0
2 bfc500 0000 0000 0
f 000000 0000 0000 0

// File: cia_subsystem.f
cia_pkg.sv
cia_bus_decoder.sv
cia_timer.sv
cia_data_combiner.sv
cia_subsystem.sv
tb_clock_gen.sv
cia_subsystem_tb.sv
